// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_csr_unit
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/common_pkg.sv ====
package common_pkg;

    localparam int XLEN = 64;                // Machine word width.

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;         // Program counter.

    // Operation class of the instruction at the memory stage.
    typedef enum logic [2:0] {
        OP_OTHER = 3'd0,
        OP_CSR   = 3'd1,                     // Register operand.
        OP_CSRI  = 3'd2,                     // Immediate operand.
        OP_ECALL = 3'd3,
        OP_MRET  = 3'd4
    } op_t;

    // CSR read-modify-write function.
    typedef enum logic [1:0] {
        ALU_CSRW = 2'd0,                     // Write.
        ALU_CSRS = 2'd1,                     // Set bits.
        ALU_CSRC = 2'd2                      // Clear bits.
    } alu_func_t;

    // Error reported by earlier stages along with the instruction.
    typedef enum logic [2:0] {
        ERR_NONE           = 3'd0,
        ERR_INSTR_MISALIGN = 3'd1,
        ERR_DECODE         = 3'd2,
        ERR_LOAD_MISALIGN  = 3'd3,
        ERR_STORE_MISALIGN = 3'd4
    } error_t;

endpackage

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Machine CSR addresses.
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
    localparam csr_addr_t CSR_SATP     = 12'h180;   // Stored only.

    // mstatus fields.
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;              // MPP is bits 12:11.

    // mie enable bits.
    localparam int MIE_MSIE = 3;
    localparam int MIE_MTIE = 7;
    localparam int MIE_MEIE = 11;

    typedef enum logic [1:0] {
        MODE_U = 2'd0,
        MODE_M = 2'd3
    } mode_t;

    // Synchronous exception causes.
    localparam common_pkg::word_t CAUSE_INSTR_MISALIGN = 64'd0;
    localparam common_pkg::word_t CAUSE_ILLEGAL        = 64'd2;
    localparam common_pkg::word_t CAUSE_LOAD_MISALIGN  = 64'd4;
    localparam common_pkg::word_t CAUSE_STORE_MISALIGN = 64'd6;
    localparam common_pkg::word_t CAUSE_ECALL_U        = 64'd8;
    localparam common_pkg::word_t CAUSE_ECALL_M        = 64'd11;

    // Interrupt causes, combined with the interrupt bit.
    localparam common_pkg::word_t IRQ_SOFT  = 64'd3;
    localparam common_pkg::word_t IRQ_TIMER = 64'd7;
    localparam common_pkg::word_t IRQ_EXT   = 64'd11;

    localparam int CAUSE_INT_BIT = 63;

    localparam common_pkg::word_t RESET_MEPC   = 64'h8000_0000;
    localparam common_pkg::word_t RESET_MCAUSE = 64'd2;

endpackage

// ==== rtl/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_addr_t   ra,
    input  csr_pkg::csr_addr_t   mem_csr_addr,
    input  common_pkg::addr_t    mem_pc,
    input  logic                 take_trap,
    input  common_pkg::word_t    trap_cause,
    input  logic                 do_mret,
    input  logic                 csr_we,
    input  csr_pkg::csr_addr_t   csr_waddr,
    input  common_pkg::word_t    csr_wdata,
    output common_pkg::word_t    rd,
    output common_pkg::word_t    csr_old,
    output common_pkg::word_t    mstatus,
    output common_pkg::word_t    mie,
    output common_pkg::word_t    mtvec,
    output common_pkg::word_t    mepc,
    output csr_pkg::mode_t       mode
);
    import common_pkg::*;
    import csr_pkg::*;

    word_t mip;
    word_t mscratch;
    word_t mcause;
    word_t mtval;
    word_t mcycle;
    word_t satp;

    function automatic word_t read_csr(input csr_addr_t addr);
        word_t data;
        case (addr)
            CSR_MSTATUS:  data = mstatus;
            CSR_MIE:      data = mie;
            CSR_MIP:      data = mip;
            CSR_MTVEC:    data = mtvec;
            CSR_MSCRATCH: data = mscratch;
            CSR_MEPC:     data = mepc;
            CSR_MCAUSE:   data = mcause;
            CSR_MTVAL:    data = mtval;
            CSR_MCYCLE:   data = mcycle;
            CSR_SATP:     data = satp;
            default:      data = '0;          // Unknown addresses read zero.
        endcase
        return data;
    endfunction

    always_comb begin
        rd      = read_csr(ra);                // Decode stage port.
        csr_old = read_csr(mem_csr_addr);      // Memory stage port.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            mie      <= '0;
            mip      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= RESET_MEPC;
            mcause   <= RESET_MCAUSE;
            mtval    <= '0;
            mcycle   <= '0;
            satp     <= '0;
            mode     <= MODE_M;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (take_trap) begin
                mepc                              <= mem_pc;
                mcause                            <= trap_cause;
                mstatus[MSTATUS_MPIE]             <= mstatus[MSTATUS_MIE];
                mstatus[MSTATUS_MIE]              <= 1'b0;  // Traps enter with interrupts off.
                mstatus[MSTATUS_MPP_LO +: 2]      <= mode;
                mode                              <= MODE_M;
            end else if (do_mret) begin
                mstatus[MSTATUS_MIE]              <= mstatus[MSTATUS_MPIE];
                mstatus[MSTATUS_MPIE]             <= 1'b1;
                mstatus[MSTATUS_MPP_LO +: 2]      <= MODE_U;
                mode <= mode_t'(mstatus[MSTATUS_MPP_LO +: 2]);  // Back to the saved mode.
            end else if (csr_we) begin
                case (csr_waddr)
                    CSR_MSTATUS:  mstatus  <= csr_wdata;
                    CSR_MIE:      mie      <= csr_wdata;
                    CSR_MIP:      mip      <= csr_wdata;
                    CSR_MTVEC:    mtvec    <= csr_wdata;
                    CSR_MSCRATCH: mscratch <= csr_wdata;
                    CSR_MEPC:     mepc     <= csr_wdata;
                    CSR_MCAUSE:   mcause   <= csr_wdata;
                    CSR_MTVAL:    mtval    <= csr_wdata;
                    CSR_MCYCLE:   mcycle   <= csr_wdata;  // Replaces the increment.
                    CSR_SATP:     satp     <= csr_wdata;
                    default:      ;
                endcase
            end
        end
    end

endmodule

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_valid,
    input  logic                   mem_stall,
    input  common_pkg::addr_t      mem_pc,
    input  common_pkg::op_t        mem_op,
    input  common_pkg::alu_func_t  mem_alu_func,
    input  common_pkg::error_t     mem_error,
    input  csr_pkg::csr_addr_t     mem_csr_addr,
    input  common_pkg::word_t      mem_csr_operand,
    input  logic                   timer_irq,
    input  logic                   soft_irq,
    input  logic                   ext_irq,
    input  csr_pkg::csr_addr_t     ra,
    output common_pkg::word_t      rd,
    output logic                   flush,
    output common_pkg::addr_t      redirect_pc
);
    import common_pkg::*;
    import csr_pkg::*;

    word_t     csr_old;
    word_t     mstatus;
    word_t     mie;
    word_t     mtvec;
    word_t     mepc;
    mode_t     mode;
    logic      take_trap;
    word_t     trap_cause;
    logic      do_mret;
    logic      csr_we;
    csr_addr_t csr_waddr;
    word_t     csr_wdata;

    trap_unit u_trap_unit (
        .mem_valid       (mem_valid),
        .mem_stall       (mem_stall),
        .mem_pc          (mem_pc),
        .mem_op          (mem_op),
        .mem_alu_func    (mem_alu_func),
        .mem_error       (mem_error),
        .mem_csr_addr    (mem_csr_addr),
        .mem_csr_operand (mem_csr_operand),
        .timer_irq       (timer_irq),
        .soft_irq        (soft_irq),
        .ext_irq         (ext_irq),
        .csr_old         (csr_old),
        .mstatus         (mstatus),
        .mie             (mie),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mode            (mode),
        .take_trap       (take_trap),
        .do_mret         (do_mret),
        .csr_we          (csr_we),
        .trap_cause      (trap_cause),
        .csr_waddr       (csr_waddr),
        .csr_wdata       (csr_wdata),
        .flush           (flush),
        .redirect_pc     (redirect_pc)
    );

    csr_regs u_csr_regs (
        .clk          (clk),
        .reset        (reset),
        .ra           (ra),
        .mem_csr_addr (mem_csr_addr),
        .mem_pc       (mem_pc),
        .take_trap    (take_trap),
        .trap_cause   (trap_cause),
        .do_mret      (do_mret),
        .csr_we       (csr_we),
        .csr_waddr    (csr_waddr),
        .csr_wdata    (csr_wdata),
        .rd           (rd),
        .csr_old      (csr_old),
        .mstatus      (mstatus),
        .mie          (mie),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .mode         (mode)
    );

endmodule

// ==== rtl/trap_unit.sv ====
`timescale 1ns/1ps

module trap_unit (
    input  logic                   mem_valid,
    input  logic                   mem_stall,
    input  common_pkg::addr_t      mem_pc,
    input  common_pkg::op_t        mem_op,
    input  common_pkg::alu_func_t  mem_alu_func,
    input  common_pkg::error_t     mem_error,
    input  csr_pkg::csr_addr_t     mem_csr_addr,
    input  common_pkg::word_t      mem_csr_operand,
    input  logic                   timer_irq,
    input  logic                   soft_irq,
    input  logic                   ext_irq,
    input  common_pkg::word_t      csr_old,
    input  common_pkg::word_t      mstatus,
    input  common_pkg::word_t      mie,
    input  common_pkg::word_t      mtvec,
    input  common_pkg::word_t      mepc,
    input  csr_pkg::mode_t         mode,
    output logic                   take_trap,
    output logic                   do_mret,
    output logic                   csr_we,
    output common_pkg::word_t      trap_cause,
    output csr_pkg::csr_addr_t     csr_waddr,
    output common_pkg::word_t      csr_wdata,
    output logic                   flush,
    output common_pkg::addr_t      redirect_pc
);
    import common_pkg::*;
    import csr_pkg::*;

    logic  active;
    logic  exc_event;
    logic  irq_pending;
    logic  irq_event;
    logic  csr_event;
    logic  mret_event;
    word_t exc_cause;
    word_t irq_cause;
    word_t rmw_result;

    // A stalled record is offered again next cycle.
    assign active = mem_valid && !mem_stall;

    assign exc_event = active && (mem_error != ERR_NONE || mem_op == OP_ECALL);

    assign irq_pending = (timer_irq && mie[MIE_MTIE]) ||
                         (soft_irq  && mie[MIE_MSIE]) ||
                         (ext_irq   && mie[MIE_MEIE]);
    assign irq_event   = active && mstatus[MSTATUS_MIE] && irq_pending;

    assign csr_event  = active && (mem_op == OP_CSR || mem_op == OP_CSRI);
    assign mret_event = active && mem_op == OP_MRET;

    always_comb begin
        case (mem_error)
            ERR_INSTR_MISALIGN: exc_cause = CAUSE_INSTR_MISALIGN;
            ERR_DECODE:         exc_cause = CAUSE_ILLEGAL;
            ERR_LOAD_MISALIGN:  exc_cause = CAUSE_LOAD_MISALIGN;
            ERR_STORE_MISALIGN: exc_cause = CAUSE_STORE_MISALIGN;
            default:            exc_cause = (mode == MODE_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
        endcase
    end

    // Cause picks by raw line level, not by enable.
    always_comb begin
        irq_cause = '0;
        irq_cause[CAUSE_INT_BIT] = 1'b1;
        if (timer_irq) begin
            irq_cause = irq_cause | IRQ_TIMER;
        end else if (soft_irq) begin
            irq_cause = irq_cause | IRQ_SOFT;
        end else begin
            irq_cause = irq_cause | IRQ_EXT;
        end
    end

    always_comb begin
        case (mem_alu_func)
            ALU_CSRW: rmw_result = mem_csr_operand;
            ALU_CSRS: rmw_result = csr_old | mem_csr_operand;
            ALU_CSRC: rmw_result = csr_old & ~mem_csr_operand;
            default:  rmw_result = csr_old;   // Leaves the register as it is.
        endcase
    end

    assign csr_waddr = mem_csr_addr;
    assign csr_wdata = rmw_result;

    // Event priority: exception, interrupt, CSR op, MRET.
    always_comb begin
        take_trap   = 1'b0;
        trap_cause  = '0;
        do_mret     = 1'b0;
        csr_we      = 1'b0;
        flush       = 1'b0;
        redirect_pc = '0;
        if (exc_event) begin
            take_trap   = 1'b1;
            trap_cause  = exc_cause;
            flush       = 1'b1;
            redirect_pc = mtvec;
        end else if (irq_event) begin
            take_trap   = 1'b1;
            trap_cause  = irq_cause;
            flush       = 1'b1;
            redirect_pc = mtvec;
        end else if (csr_event) begin
            csr_we      = 1'b1;
            flush       = 1'b1;
            redirect_pc = mem_pc + 64'd4;     // Refetch after the CSR op.
        end else if (mret_event) begin
            do_mret     = 1'b1;
            flush       = 1'b1;
            redirect_pc = mepc;
        end
    end

endmodule

// ==== tb.f ====
rtl/common_pkg.sv
rtl/csr_pkg.sv
rtl/trap_unit.sv
rtl/csr_regs.sv
rtl/csr_unit.sv
tests/csr_checker.sv
tests/tb_csr_unit.sv

// ==== tests/csr_checker.sv ====
`timescale 1ns/1ps

module csr_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_valid,
    input  logic                   mem_stall,
    input  common_pkg::addr_t      mem_pc,
    input  common_pkg::op_t        mem_op,
    input  common_pkg::alu_func_t  mem_alu_func,
    input  common_pkg::error_t     mem_error,
    input  csr_pkg::csr_addr_t     mem_csr_addr,
    input  common_pkg::word_t      mem_csr_operand,
    input  logic                   timer_irq,
    input  logic                   soft_irq,
    input  logic                   ext_irq,
    input  csr_pkg::csr_addr_t     ra,
    input  common_pkg::word_t      rd,
    input  logic                   flush,
    input  common_pkg::addr_t      redirect_pc,
    output int                     error_count,
    output int                     check_count
);
    import common_pkg::*;
    import csr_pkg::*;

    typedef struct packed {
        word_t      mstatus;
        word_t      mie;
        word_t      mip;
        word_t      mtvec;
        word_t      mscratch;
        word_t      mepc;
        word_t      mcause;
        word_t      mtval;
        word_t      mcycle;
        word_t      satp;
        logic [1:0] mode;
    } state_t;

    state_t model;
    state_t next_model;
    logic   exp_flush;
    addr_t  exp_redirect;
    string  test_name;

    function automatic state_t reset_state();
        state_t s;
        s        = '0;
        s.mepc   = 64'h8000_0000;
        s.mcause = 64'd2;
        s.mode   = 2'd3;                             // Machine mode.
        return s;
    endfunction

    function automatic word_t read_model(input state_t s, input csr_addr_t a);
        case (a)
            CSR_MSTATUS:  return s.mstatus;
            CSR_MIE:      return s.mie;
            CSR_MIP:      return s.mip;
            CSR_MTVEC:    return s.mtvec;
            CSR_MSCRATCH: return s.mscratch;
            CSR_MEPC:     return s.mepc;
            CSR_MCAUSE:   return s.mcause;
            CSR_MTVAL:    return s.mtval;
            CSR_MCYCLE:   return s.mcycle;
            CSR_SATP:     return s.satp;
            default:      return '0;
        endcase
    endfunction

    function automatic state_t write_model(input state_t s, input csr_addr_t a, input word_t v);
        state_t n;
        n = s;
        case (a)
            CSR_MSTATUS:  n.mstatus  = v;
            CSR_MIE:      n.mie      = v;
            CSR_MIP:      n.mip      = v;
            CSR_MTVEC:    n.mtvec    = v;
            CSR_MSCRATCH: n.mscratch = v;
            CSR_MEPC:     n.mepc     = v;
            CSR_MCAUSE:   n.mcause   = v;
            CSR_MTVAL:    n.mtval    = v;
            CSR_MCYCLE:   n.mcycle   = v;            // Overrides the increment.
            CSR_SATP:     n.satp     = v;
            default:      ;
        endcase
        return n;
    endfunction

    // Expected flush, redirect and next state for one cycle.
    function automatic void step_model(
        input  state_t     s,
        input  logic       valid,
        input  logic       stall,
        input  addr_t      pc,
        input  op_t        op,
        input  alu_func_t  func,
        input  error_t     err,
        input  csr_addr_t  addr,
        input  word_t      operand,
        input  logic       t_irq,
        input  logic       s_irq,
        input  logic       e_irq,
        output logic       f,
        output addr_t      target,
        output state_t     n,
        output string      test
    );
        logic  active;
        logic  irq_on;
        logic  trap;
        word_t cause;
        word_t old;
        word_t value;
        active = valid && !stall;
        irq_on = (t_irq && s.mie[7]) || (s_irq && s.mie[3]) || (e_irq && s.mie[11]);
        trap   = 1'b0;
        cause  = '0;
        f      = 1'b0;
        target = '0;
        n      = s;
        n.mcycle = s.mcycle + 64'd1;
        test   = stall ? "stall_counter" : "idle";
        if (active && (err != ERR_NONE || op == OP_ECALL)) begin
            test = "exception";
            trap = 1'b1;
            case (err)
                ERR_INSTR_MISALIGN: cause = 64'd0;
                ERR_DECODE:         cause = 64'd2;
                ERR_LOAD_MISALIGN:  cause = 64'd4;
                ERR_STORE_MISALIGN: cause = 64'd6;
                default:            cause = (s.mode == 2'd0) ? 64'd8 : 64'd11;
            endcase
        end else if (active && s.mstatus[3] && irq_on) begin
            test  = "interrupt";
            trap  = 1'b1;
            cause = (64'd1 << 63) | (t_irq ? 64'd7 : (s_irq ? 64'd3 : 64'd11));
        end else if (active && (op == OP_CSR || op == OP_CSRI)) begin
            test = "csr_op";
            old  = read_model(s, addr);
            case (func)
                ALU_CSRW: value = operand;
                ALU_CSRS: value = old | operand;
                ALU_CSRC: value = old & ~operand;
                default:  value = old;
            endcase
            n      = write_model(n, addr, value);
            f      = 1'b1;
            target = pc + 64'd4;
        end else if (active && op == OP_MRET) begin
            test          = "mret";
            n.mstatus[3]  = s.mstatus[7];
            n.mstatus[7]  = 1'b1;
            n.mstatus[12:11] = 2'd0;
            n.mode        = s.mstatus[12:11];
            f             = 1'b1;
            target        = s.mepc;
        end
        if (trap) begin
            n.mepc           = pc;
            n.mcause         = cause;
            n.mstatus[7]     = s.mstatus[3];         // MPIE from MIE.
            n.mstatus[3]     = 1'b0;
            n.mstatus[12:11] = s.mode;
            n.mode           = 2'd3;
            f                = 1'b1;
            target           = s.mtvec;
        end
    endfunction

    task automatic compare(input string test, input string sig, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s %s expected %h actual %h", test, sig, exp, act);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(negedge clk) begin
        if (!reset) begin
            step_model(model, mem_valid, mem_stall, mem_pc, mem_op, mem_alu_func, mem_error,
                       mem_csr_addr, mem_csr_operand, timer_irq, soft_irq, ext_irq,
                       exp_flush, exp_redirect, next_model, test_name);
            compare(test_name, "flush", {63'd0, exp_flush}, {63'd0, flush});
            compare(test_name, "redirect_pc", exp_redirect, redirect_pc);
            compare(test_name, "rd", read_model(model, ra), rd);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            model <= reset_state();
        end else begin
            model <= next_model;
        end
    end

endmodule

// ==== tests/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit;
    import common_pkg::*;
    import csr_pkg::*;

    localparam int RANDOM_CYCLES  = 2000;
    localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + 200;   // Prologue needs under 20.

    logic        clk;
    logic        reset;
    logic        mem_valid;
    logic        mem_stall;
    addr_t       mem_pc;
    op_t         mem_op;
    alu_func_t   mem_alu_func;
    error_t      mem_error;
    csr_addr_t   mem_csr_addr;
    word_t       mem_csr_operand;
    logic        timer_irq;
    logic        soft_irq;
    logic        ext_irq;
    csr_addr_t   ra;
    word_t       rd;
    logic        flush;
    addr_t       redirect_pc;
    int          error_count;
    int          check_count;
    int          cycle_count;
    logic [31:0] seed;

    csr_unit u_csr_unit (
        .clk (clk), .reset (reset), .mem_valid (mem_valid), .mem_stall (mem_stall),
        .mem_pc (mem_pc), .mem_op (mem_op), .mem_alu_func (mem_alu_func),
        .mem_error (mem_error), .mem_csr_addr (mem_csr_addr),
        .mem_csr_operand (mem_csr_operand), .timer_irq (timer_irq), .soft_irq (soft_irq),
        .ext_irq (ext_irq), .ra (ra), .rd (rd), .flush (flush), .redirect_pc (redirect_pc)
    );

    csr_checker u_csr_checker (
        .clk (clk), .reset (reset), .mem_valid (mem_valid), .mem_stall (mem_stall),
        .mem_pc (mem_pc), .mem_op (mem_op), .mem_alu_func (mem_alu_func),
        .mem_error (mem_error), .mem_csr_addr (mem_csr_addr),
        .mem_csr_operand (mem_csr_operand), .timer_irq (timer_irq), .soft_irq (soft_irq),
        .ext_irq (ext_irq), .ra (ra), .rd (rd), .flush (flush), .redirect_pc (redirect_pc),
        .error_count (error_count), .check_count (check_count)
    );

    always #4 clk = ~clk;                             // 8 ns period.

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(input int limit, output int value);
        seed  = lcg(seed);
        value = int'(seed[31:8]) % limit;             // Upper bits are less regular.
    endtask

    task automatic draw_word(output word_t value);
        logic [31:0] hi;
        seed  = lcg(seed);
        hi    = seed;
        seed  = lcg(seed);
        value = {hi, seed};
    endtask

    // Indices 0 to 4 are the common targets, 10 is unmapped.
    function automatic csr_addr_t addr_at(input int idx);
        case (idx)
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MTVEC;
            3:       return CSR_MSCRATCH;
            4:       return CSR_MEPC;
            5:       return CSR_MCAUSE;
            6:       return CSR_MTVAL;
            7:       return CSR_MIP;
            8:       return CSR_MCYCLE;
            9:       return CSR_SATP;
            default: return 12'h7C0;
        endcase
    endfunction

    task automatic idle_inputs();
        mem_valid       = 1'b0;
        mem_stall       = 1'b0;
        mem_pc          = '0;
        mem_op          = OP_OTHER;
        mem_alu_func    = ALU_CSRW;
        mem_error       = ERR_NONE;
        mem_csr_addr    = '0;
        mem_csr_operand = '0;
        timer_irq       = 1'b0;
        soft_irq        = 1'b0;
        ext_irq         = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_csr(input op_t op, input alu_func_t func, input csr_addr_t addr,
                             input word_t operand, input addr_t pc);
        idle_inputs();
        mem_valid       = 1'b1;
        mem_op          = op;
        mem_alu_func    = func;
        mem_csr_addr    = addr;
        mem_csr_operand = operand;
        mem_pc          = pc;
        next_cycle();
    endtask

    task automatic random_record();
        int    r;
        int    idx;
        word_t value;
        draw(100, r);
        mem_valid = (r < 60);
        draw(100, r);
        mem_stall = (r < 15);
        draw(100, r);
        if (r < 45) mem_op = OP_CSR;
        else if (r < 60) mem_op = OP_CSRI;
        else if (r < 65) mem_op = OP_ECALL;
        else if (r < 71) mem_op = OP_MRET;
        else mem_op = OP_OTHER;
        draw(100, r);
        case (r)
            0, 1:    mem_error = ERR_INSTR_MISALIGN;
            2, 3:    mem_error = ERR_DECODE;
            4, 5:    mem_error = ERR_LOAD_MISALIGN;
            6, 7:    mem_error = ERR_STORE_MISALIGN;
            default: mem_error = ERR_NONE;
        endcase
        draw(3, r);
        case (r)
            0:       mem_alu_func = ALU_CSRW;
            1:       mem_alu_func = ALU_CSRS;
            default: mem_alu_func = ALU_CSRC;
        endcase
        draw(100, r);
        if (r < 80) draw(5, idx);
        else begin
            draw(6, idx);
            idx = idx + 5;
        end
        mem_csr_addr = addr_at(idx);
        draw(4, r);
        if (r == 0) draw_word(value);
        else begin
            draw(4, idx);
            value = 64'd1 << ((idx == 3) ? 12 : (idx * 4 + 3));   // MIE, MPIE, MPP bits.
        end
        mem_csr_operand = (mem_op == OP_CSRI) ? (value & 64'd31) : value;
        draw_word(value);
        mem_pc = value & ~64'd3;
        draw(100, r);
        timer_irq = (r < 4);
        draw(100, r);
        soft_irq = (r < 4);
        draw(100, r);
        ext_irq = (r < 4);
        draw(11, r);
        ra = addr_at(r);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        seed  = 32'h6166_913d;
        ra    = '0;
        idle_inputs();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 11; i++) begin        // Reset values on the read port.
            ra = addr_at(i);
            next_cycle();
        end
        issue_csr(OP_CSR, ALU_CSRW, CSR_MTVEC, 64'h0000_0000_0000_1000, 64'h8000_0000);
        issue_csr(OP_CSRI, ALU_CSRS, CSR_MSTATUS, 64'd8, 64'h8000_0004);
        issue_csr(OP_CSR, ALU_CSRW, CSR_MIE, '1, 64'h8000_0008);
        repeat (RANDOM_CYCLES) begin
            random_record();
            next_cycle();
        end
        idle_inputs();
        next_cycle();
        @(negedge clk);
        #1;
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
